// File: design/l2_pkg.sv
/*
  Shared types and sizes of the L2 memory path.
  Addresses are doubleword addresses with no byte offset; tag and idx
  together pick one of MemLines lines. There is no real tag compare.
  Tag and idx widths must add up to the line memory address width.
*/
package l2_pkg;

  // Doubleword width
  localparam int unsigned XLEN = 64;
  // Doublewords per line
  localparam int unsigned LineDw = 4;
  localparam int unsigned LineW = XLEN * LineDw;
  // Number of lines held by the line memory
  localparam int unsigned MemLines = 64;
  localparam int unsigned MemAddrW = $clog2(MemLines);

  // Request buffer depth and hit latency in countdown cycles
  localparam int unsigned BufLen = 3;
  localparam int unsigned BufIdxW = $clog2(BufLen);
  localparam int unsigned HitDelay = 2;
  localparam int unsigned TimerW = $clog2(HitDelay + 1);

  // Clients sharing the L2 port
  localparam int unsigned NumClients = 3;

  // Address field widths
  localparam int unsigned TagW = 2;
  localparam int unsigned IdxW = 4;
  localparam int unsigned OffW = $clog2(LineDw);
  localparam int unsigned WbbTagW = 4;

  typedef logic [LineW-1:0] line_t;

  // One doubleword address; {tag, idx} is the line address
  typedef struct packed {
    logic [TagW-1:0] tag;
    logic [IdxW-1:0] idx;
    logic [OffW-1:0] line_off;
  } paddr_t;

  // Request opcodes
  typedef enum logic [1:0] {
    IReadLine,
    DReadLine,
    DWriteLine,
    PTWLoad
  } l2_req_type_e;

  // Answer opcodes, one per request opcode
  typedef enum logic [1:0] {
    ILineRead,
    DLineRead,
    DLineWritten,
    PTWLoaded
  } l2_ans_type_e;

  // Owner of a request
  typedef enum logic [1:0] {
    Icache,
    Dcache,
    Ptw
  } client_e;

  // Request channel payload, line is the write data of DWriteLine
  typedef struct packed {
    logic                valid;
    l2_req_type_e        req_type;
    paddr_t              paddr;
    line_t               line;
    logic [WbbTagW-1:0]  wbb_tag;
  } l2_req_t;

  // Answer channel payload
  typedef struct packed {
    logic                valid;
    l2_ans_type_e        ans_type;
    paddr_t              paddr;
    line_t               line;
    logic [XLEN-1:0]     data;
    logic [WbbTagW-1:0]  wbb_tag;
  } l2_ans_t;

endpackage

// File: design/l2_line_mem.sv
/*
  Line storage of the L2 model.
  Combinational read of one line, synchronous write of one line.
  The whole array clears to zero on the asynchronous reset.
  A read of the line being written returns the old contents.
*/
module l2_line_mem (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read port
  input  logic [l2_pkg::MemAddrW-1:0] raddr_i,
  output l2_pkg::line_t               rline_o,
  // Write port
  input  logic                        we_i,
  input  logic [l2_pkg::MemAddrW-1:0] waddr_i,
  input  l2_pkg::line_t               wline_i
);

  l2_pkg::line_t mem_q [l2_pkg::MemLines];

  // Write one line per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < l2_pkg::MemLines; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wline_i;
    end
  end

  // Read path has no register
  assign rline_o = mem_q[raddr_i];

endmodule

// File: design/l2_arbiter.sv
/*
  Round-robin arbiter for the three L2 clients.
  Fully combinational on both paths; only the grant pointer is a register.
  Answers are routed by opcode, so each opcode must belong to one client.
*/
module l2_arbiter (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Client request channels
  input  l2_pkg::l2_req_t ic_req_i,
  output logic            ic_req_rdy_o,
  input  l2_pkg::l2_req_t dc_req_i,
  output logic            dc_req_rdy_o,
  input  l2_pkg::l2_req_t ptw_req_i,
  output logic            ptw_req_rdy_o,
  // Merged request channel to the buffer
  output l2_pkg::l2_req_t arb_req_o,
  input  logic            arb_req_rdy_i,
  // Answer channel from the buffer
  input  l2_pkg::l2_ans_t buf_ans_i,
  output logic            buf_ans_rdy_o,
  // Client answer channels
  output l2_pkg::l2_ans_t ic_ans_o,
  input  logic            ic_ans_rdy_i,
  output l2_pkg::l2_ans_t dc_ans_o,
  input  logic            dc_ans_rdy_i,
  output l2_pkg::l2_ans_t ptw_ans_o,
  input  logic            ptw_ans_rdy_i
);

  l2_pkg::l2_req_t [l2_pkg::NumClients-1:0] req_vec;
  l2_pkg::client_e ptr_q;
  l2_pkg::client_e grant;
  logic            found;
  l2_pkg::client_e owner;

  // Client reached n steps after c in round-robin order
  function automatic l2_pkg::client_e step_client(l2_pkg::client_e c, int unsigned n);
    int unsigned sum;
    sum = (int'(c) + n) % l2_pkg::NumClients;
    return l2_pkg::client_e'(sum);
  endfunction

  // Index order follows client_e
  assign req_vec = {ptw_req_i, dc_req_i, ic_req_i};

  // First valid client at or after the pointer
  always_comb begin
    l2_pkg::client_e cand;
    grant = ptr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < l2_pkg::NumClients; i++) begin
      cand = step_client(ptr_q, i);
      if (!found && req_vec[cand].valid) begin
        grant = cand;
        found = 1'b1;
      end
    end
  end

  assign arb_req_o = found ? req_vec[grant] : '0;

  // Buffer ready goes to the granted client only
  assign ic_req_rdy_o  = arb_req_rdy_i && found && (grant == l2_pkg::Icache);
  assign dc_req_rdy_o  = arb_req_rdy_i && found && (grant == l2_pkg::Dcache);
  assign ptw_req_rdy_o = arb_req_rdy_i && found && (grant == l2_pkg::Ptw);

  // Pointer moves one past the winner after each transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= l2_pkg::Icache;
    end else if (arb_req_o.valid && arb_req_rdy_i) begin
      ptr_q <= step_client(grant, 1);
    end
  end

  // Answer owner from the opcode
  always_comb begin
    case (buf_ans_i.ans_type)
      l2_pkg::ILineRead: owner = l2_pkg::Icache;
      l2_pkg::PTWLoaded: owner = l2_pkg::Ptw;
      default:           owner = l2_pkg::Dcache;
    endcase
  end

  // Same payload everywhere, valid only at the owner
  always_comb begin
    ic_ans_o        = buf_ans_i;
    dc_ans_o        = buf_ans_i;
    ptw_ans_o       = buf_ans_i;
    ic_ans_o.valid  = buf_ans_i.valid && (owner == l2_pkg::Icache);
    dc_ans_o.valid  = buf_ans_i.valid && (owner == l2_pkg::Dcache);
    ptw_ans_o.valid = buf_ans_i.valid && (owner == l2_pkg::Ptw);
  end

  // Owner's ready back to the buffer
  always_comb begin
    case (owner)
      l2_pkg::Icache: buf_ans_rdy_o = ic_ans_rdy_i;
      l2_pkg::Ptw:    buf_ans_rdy_o = ptw_ans_rdy_i;
      default:        buf_ans_rdy_o = dc_ans_rdy_i;
    endcase
  end

endmodule

// File: design/l2_req_buffer.sv
/*
  Non-blocking L2 request buffer, every request is a hit.
  Each entry counts down HitDelay cycles, then answers from the line memory.
  One acceptance per cycle keeps answers in acceptance order.
  A flush drops all entries and their pending writes but keeps the answer register.
*/
module l2_req_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // Request channel from the arbiter
  input  l2_pkg::l2_req_t               req_i,
  output logic                          req_rdy_o,
  // Answer channel to the arbiter
  output l2_pkg::l2_ans_t               ans_o,
  input  logic                          ans_rdy_i,
  // Line memory ports
  output logic [l2_pkg::MemAddrW-1:0]   mem_raddr_o,
  input  l2_pkg::line_t                 mem_rline_i,
  output logic                          mem_we_o,
  output logic [l2_pkg::MemAddrW-1:0]   mem_waddr_o,
  output l2_pkg::line_t                 mem_wline_o
);

  // Stored part of a request
  typedef struct packed {
    l2_pkg::l2_req_type_e               req_type;
    l2_pkg::paddr_t                     paddr;
    l2_pkg::line_t                      line;
    logic [l2_pkg::WbbTagW-1:0]         wbb_tag;
  } entry_t;

  logic [l2_pkg::BufLen-1:0]  ent_valid_q;
  logic [l2_pkg::TimerW-1:0]  timer_q [l2_pkg::BufLen];
  entry_t                     ent_q [l2_pkg::BufLen];

  logic [l2_pkg::BufIdxW-1:0] free_idx;
  logic                       free_valid;
  logic [l2_pkg::BufIdxW-1:0] leave_idx;
  logic                       leave_valid;
  logic [l2_pkg::BufIdxW-1:0] ins_idx;
  logic                       stalled;
  logic                       leave_fire;
  logic                       accept;
  entry_t                     leave_ent;
  l2_pkg::l2_ans_t            ans_d;
  l2_pkg::l2_ans_t            ans_q;

  // Answer held while its ready is low
  assign stalled = ans_q.valid && !ans_rdy_i;

  // Lowest free entry
  always_comb begin
    free_idx   = '0;
    free_valid = 1'b0;
    for (int k = l2_pkg::BufLen - 1; k >= 0; k--) begin
      if (!ent_valid_q[k]) begin
        free_idx   = l2_pkg::BufIdxW'(k);
        free_valid = 1'b1;
      end
    end
  end

  // Entry whose timer ran out, at most one by construction
  always_comb begin
    leave_idx   = '0;
    leave_valid = 1'b0;
    for (int k = l2_pkg::BufLen - 1; k >= 0; k--) begin
      if (ent_valid_q[k] && (timer_q[k] == '0)) begin
        leave_idx   = l2_pkg::BufIdxW'(k);
        leave_valid = 1'b1;
      end
    end
  end

  // Flush kills the leaving entry too
  assign leave_fire = leave_valid && !stalled && !flush_i;

  // Ready needs a free slot or the slot freed this cycle
  assign req_rdy_o = !stalled && !flush_i && (free_valid || leave_valid);
  assign accept    = req_i.valid && req_rdy_o;
  // Reuse the leaving slot only when the buffer is full
  assign ins_idx   = free_valid ? free_idx : leave_idx;

  // Entry valid bits and timers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ent_valid_q <= '0;
      for (int k = 0; k < l2_pkg::BufLen; k++) begin
        timer_q[k] <= '0;
      end
    end else if (flush_i) begin
      ent_valid_q <= '0;
    end else begin
      for (int k = 0; k < l2_pkg::BufLen; k++) begin
        if (accept && (ins_idx == l2_pkg::BufIdxW'(k))) begin
          ent_valid_q[k] <= 1'b1;
          timer_q[k]     <= l2_pkg::TimerW'(l2_pkg::HitDelay);
        end else if (leave_fire && (leave_idx == l2_pkg::BufIdxW'(k))) begin
          ent_valid_q[k] <= 1'b0;
        end else if (!stalled && ent_valid_q[k] && (timer_q[k] != '0)) begin
          // All live timers move together
          timer_q[k] <= timer_q[k] - 1'b1;
        end
      end
    end
  end

  // Request payload capture
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < l2_pkg::BufLen; k++) begin
      if (accept && (ins_idx == l2_pkg::BufIdxW'(k))) begin
        ent_q[k].req_type <= req_i.req_type;
        ent_q[k].paddr    <= req_i.paddr;
        ent_q[k].line     <= req_i.line;
        ent_q[k].wbb_tag  <= req_i.wbb_tag;
      end
    end
  end

  assign leave_ent = ent_q[leave_idx];

  // Memory access for the leaving entry
  assign mem_raddr_o = {leave_ent.paddr.tag, leave_ent.paddr.idx};
  assign mem_waddr_o = {leave_ent.paddr.tag, leave_ent.paddr.idx};
  assign mem_wline_o = leave_ent.line;
  // Write commits with its answer
  assign mem_we_o    = leave_fire && (leave_ent.req_type == l2_pkg::DWriteLine);

  // Next answer from the leaving entry
  always_comb begin
    ans_d         = '0;
    ans_d.valid   = 1'b1;
    ans_d.paddr   = leave_ent.paddr;
    ans_d.wbb_tag = leave_ent.wbb_tag;
    case (leave_ent.req_type)
      l2_pkg::IReadLine: begin
        ans_d.ans_type = l2_pkg::ILineRead;
        ans_d.line     = mem_rline_i;
      end
      l2_pkg::DReadLine: begin
        ans_d.ans_type = l2_pkg::DLineRead;
        ans_d.line     = mem_rline_i;
      end
      l2_pkg::DWriteLine: begin
        ans_d.ans_type = l2_pkg::DLineWritten;
      end
      l2_pkg::PTWLoad: begin
        ans_d.ans_type = l2_pkg::PTWLoaded;
        // Doubleword picked by the line offset
        ans_d.data = mem_rline_i[leave_ent.paddr.line_off * l2_pkg::XLEN +: l2_pkg::XLEN];
      end
      default: ans_d.valid = 1'b0;
    endcase
  end

  // Answer register, loaded on leave and cleared on transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_q <= '0;
    end else if (leave_fire) begin
      ans_q <= ans_d;
    end else if (ans_rdy_i) begin
      ans_q.valid <= 1'b0;
    end
  end

  assign ans_o = ans_q;

endmodule

// File: design/l2_subsystem.sv
/*
  L2 memory path: arbiter, request buffer and line memory.
  Latency is HitDelay + 1 cycles without back-pressure and grows under it.
  The answer valid marks the end of every request.
*/
module l2_subsystem (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  // Instruction cache
  input  l2_pkg::l2_req_t ic_req_i,
  output logic            ic_req_rdy_o,
  output l2_pkg::l2_ans_t ic_ans_o,
  input  logic            ic_ans_rdy_i,
  // Data cache
  input  l2_pkg::l2_req_t dc_req_i,
  output logic            dc_req_rdy_o,
  output l2_pkg::l2_ans_t dc_ans_o,
  input  logic            dc_ans_rdy_i,
  // Page-table walker
  input  l2_pkg::l2_req_t ptw_req_i,
  output logic            ptw_req_rdy_o,
  output l2_pkg::l2_ans_t ptw_ans_o,
  input  logic            ptw_ans_rdy_i
);

  l2_pkg::l2_req_t                 arb_req;
  logic                            arb_req_rdy;
  l2_pkg::l2_ans_t                 buf_ans;
  logic                            buf_ans_rdy;
  logic [l2_pkg::MemAddrW-1:0]     mem_raddr;
  l2_pkg::line_t                   mem_rline;
  logic                            mem_we;
  logic [l2_pkg::MemAddrW-1:0]     mem_waddr;
  l2_pkg::line_t                   mem_wline;

  l2_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ic_req_i      (ic_req_i),
    .ic_req_rdy_o  (ic_req_rdy_o),
    .dc_req_i      (dc_req_i),
    .dc_req_rdy_o  (dc_req_rdy_o),
    .ptw_req_i     (ptw_req_i),
    .ptw_req_rdy_o (ptw_req_rdy_o),
    .arb_req_o     (arb_req),
    .arb_req_rdy_i (arb_req_rdy),
    .buf_ans_i     (buf_ans),
    .buf_ans_rdy_o (buf_ans_rdy),
    .ic_ans_o      (ic_ans_o),
    .ic_ans_rdy_i  (ic_ans_rdy_i),
    .dc_ans_o      (dc_ans_o),
    .dc_ans_rdy_i  (dc_ans_rdy_i),
    .ptw_ans_o     (ptw_ans_o),
    .ptw_ans_rdy_i (ptw_ans_rdy_i)
  );

  l2_req_buffer i_req_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_i       (arb_req),
    .req_rdy_o   (arb_req_rdy),
    .ans_o       (buf_ans),
    .ans_rdy_i   (buf_ans_rdy),
    .mem_raddr_o (mem_raddr),
    .mem_rline_i (mem_rline),
    .mem_we_o    (mem_we),
    .mem_waddr_o (mem_waddr),
    .mem_wline_o (mem_wline)
  );

  l2_line_mem i_line_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddr_i (mem_raddr),
    .rline_o (mem_rline),
    .we_i    (mem_we),
    .waddr_i (mem_waddr),
    .wline_i (mem_wline)
  );

endmodule

// File: tb/l2_subsystem_assertions.sv
/*
  Handshake checks on the L2 request buffer, bound into every instance.
  Assumes the answer register is the only source of ans_o.
*/
module l2_subsystem_assertions (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            flush_i,
  input logic            req_rdy_o,
  input l2_pkg::l2_ans_t ans_o,
  input logic            ans_rdy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed checks
  int unsigned fail_cnt = 0;

  // A held answer must not move
  held_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ans_o.valid && !ans_rdy_i) |=> $stable(ans_o))
  else begin
    fail_cnt++;
    $error("answer changed while its ready was low");
  end

  // No acceptance while stalled or flushing
  stall_rdy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((ans_o.valid && !ans_rdy_i) || flush_i) |-> !req_rdy_o)
  else begin
    fail_cnt++;
    $error("request ready high while stalled or flushing");
  end

  // Reset leaves no answer behind
  reset_ans_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !ans_o.valid)
  else begin
    fail_cnt++;
    $error("answer valid right after reset");
  end

endmodule

bind l2_req_buffer l2_subsystem_assertions i_assertions (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .flush_i   (flush_i),
  .req_rdy_o (req_rdy_o),
  .ans_o     (ans_o),
  .ans_rdy_i (ans_rdy_i)
);

// File: tb/tb_l2_subsystem.sv
/*
  Testbench for the L2 subsystem with three LFSR-driven clients.
  Expected answers come from one ordered queue and a 64-line reference array.
  Read data is taken from the array at acceptance, since writes commit in order.
  Inputs change on the falling edge and ports are sampled 1 ns later.
*/
module tb_l2_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  // One accepted request and what it should return
  typedef struct {
    int              client;
    l2_pkg::l2_req_t req;
    l2_pkg::line_t   exp_line;
  } exp_entry_t;

  logic            clk_i;
  logic            rst_ni;
  logic            flush_i;
  l2_pkg::l2_req_t req_drv [3];
  logic [2:0]      req_rdy;
  logic [2:0]      ans_rdy;
  l2_pkg::l2_ans_t ic_ans;
  l2_pkg::l2_ans_t dc_ans;
  l2_pkg::l2_ans_t ptw_ans;

  exp_entry_t      exp_q [$];
  l2_pkg::line_t   ref_mem [l2_pkg::MemLines];
  l2_pkg::line_t   last_old;
  logic [31:0]     lfsr_q;
  logic [2:0]      done;
  int              wait_cnt [3];
  int              cyc;
  int              acc_cyc;
  logic            rand_en;
  logic            ans_seen;
  logic            held;
  int              held_c;
  l2_pkg::l2_ans_t held_ans;
  string           port_name [3] = '{"ic_ans_o", "dc_ans_o", "ptw_ans_o"};

  l2_subsystem DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .ic_req_i      (req_drv[0]),
    .ic_req_rdy_o  (req_rdy[0]),
    .ic_ans_o      (ic_ans),
    .ic_ans_rdy_i  (ans_rdy[0]),
    .dc_req_i      (req_drv[1]),
    .dc_req_rdy_o  (req_rdy[1]),
    .dc_ans_o      (dc_ans),
    .dc_ans_rdy_i  (ans_rdy[1]),
    .ptw_req_i     (req_drv[2]),
    .ptw_req_rdy_o (req_rdy[2]),
    .ptw_ans_o     (ptw_ans),
    .ptw_ans_rdy_i (ans_rdy[2])
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(string name, logic [511:0] exp, logic [511:0] act);
    if (exp !== act) begin
      stop_run($sformatf("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp, act));
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic take_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  function automatic logic [255:0] take_bits(int n);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[254:0], take_bit()};
    end
    return v;
  endfunction

  function automatic l2_pkg::l2_ans_t get_ans(int c);
    case (c)
      0:       return ic_ans;
      1:       return dc_ans;
      default: return ptw_ans;
    endcase
  endfunction

  // Opcode follows the client, only the data cache writes
  function automatic l2_pkg::l2_req_t make_req(int c);
    l2_pkg::l2_req_t r;
    logic [255:0]    b;
    r = '0;
    r.valid = 1'b1;
    case (c)
      0:       r.req_type = l2_pkg::IReadLine;
      1:       r.req_type = take_bit() ? l2_pkg::DWriteLine : l2_pkg::DReadLine;
      default: r.req_type = l2_pkg::PTWLoad;
    endcase
    b = take_bits(8);
    r.paddr = b[7:0];
    if (r.req_type == l2_pkg::DWriteLine) begin
      r.line = take_bits(256);
    end
    b = take_bits(4);
    r.wbb_tag = b[3:0];
    return r;
  endfunction

  // Falling edge: retire transferred requests, then new stimulus
  task automatic edge_drive();
    @(negedge clk_i);
    cyc++;
    for (int c = 0; c < 3; c++) begin
      if (done[c]) begin
        req_drv[c].valid = 1'b0;
        done[c] = 1'b0;
      end
    end
    for (int c = 0; c < 3; c++) begin
      if (rand_en) begin
        if (!req_drv[c].valid && (take_bits(2) != 0)) begin
          req_drv[c] = make_req(c);
        end
        ans_rdy[c] = take_bit();
      end else begin
        ans_rdy[c] = 1'b1;
      end
    end
  endtask

  task automatic check_answer(int c, l2_pkg::l2_ans_t a);
    exp_entry_t           e;
    l2_pkg::l2_ans_type_e t;
    logic [255:0]         sh;
    if (exp_q.size() == 0) begin
      stop_run("an answer arrived with no request in flight");
    end
    e = exp_q.pop_front();
    check_eq("answer owner port index", e.client, c);
    case (e.req.req_type)
      l2_pkg::IReadLine:  t = l2_pkg::ILineRead;
      l2_pkg::DReadLine:  t = l2_pkg::DLineRead;
      l2_pkg::DWriteLine: t = l2_pkg::DLineWritten;
      default:            t = l2_pkg::PTWLoaded;
    endcase
    check_eq({port_name[c], ".ans_type"}, t, a.ans_type);
    check_eq({port_name[c], ".paddr"}, e.req.paddr, a.paddr);
    check_eq({port_name[c], ".wbb_tag"}, e.req.wbb_tag, a.wbb_tag);
    if ((t == l2_pkg::ILineRead) || (t == l2_pkg::DLineRead)) begin
      check_eq({port_name[c], ".line"}, e.exp_line, a.line);
    end
    if (t == l2_pkg::PTWLoaded) begin
      // Doubleword 0 sits in the low bits of the line
      sh = e.exp_line >> (64 * e.req.paddr.line_off);
      check_eq({port_name[c], ".data"}, sh[63:0], a.data);
    end
  endtask

  task automatic record_request(int g);
    exp_entry_t e;
    logic [5:0] la;
    e.client = g;
    e.req    = req_drv[g];
    la       = {e.req.paddr.tag, e.req.paddr.idx};
    if (e.req.req_type == l2_pkg::DWriteLine) begin
      last_old    = ref_mem[la];
      ref_mem[la] = e.req.line;
    end
    e.exp_line = ref_mem[la];
    exp_q.push_back(e);
    acc_cyc = cyc;
    done[g] = 1'b1;
  endtask

  // Settled values here are what the next rising edge transfers
  task automatic sample_ports();
    l2_pkg::l2_ans_t a;
    int              nans;
    int              ac;
    int              nxfer;
    int              g;
    #1;
    if (DUT.i_req_buffer.i_assertions.fail_cnt != 0) begin
      stop_run("a handshake assertion on the request buffer failed");
    end
    if (held) begin
      check_eq({port_name[held_c], " while held"}, held_ans, get_ans(held_c));
    end
    nans = 0;
    ac   = 0;
    for (int c = 0; c < 3; c++) begin
      a = get_ans(c);
      if (a.valid) begin
        nans++;
        ac = c;
      end
    end
    if (nans > 1) begin
      stop_run("an answer was valid on more than one client port");
    end
    ans_seen = (nans == 1);
    held     = 1'b0;
    if (ans_seen) begin
      a = get_ans(ac);
      if (ans_rdy[ac]) begin
        check_answer(ac, a);
      end else begin
        held     = 1'b1;
        held_c   = ac;
        held_ans = a;
      end
    end
    nxfer = 0;
    g     = 0;
    for (int c = 0; c < 3; c++) begin
      if (req_drv[c].valid && req_rdy[c]) begin
        nxfer++;
        g = c;
      end
    end
    if (nxfer > 1) begin
      stop_run("more than one client was granted in the same cycle");
    end
    if (nxfer == 1) begin
      // Waiting clients count the transfers of the others
      for (int c = 0; c < 3; c++) begin
        if ((c != g) && req_drv[c].valid) begin
          wait_cnt[c]++;
        end
      end
      if (wait_cnt[g] > 2) begin
        stop_run($sformatf("client %0d waited %0d transfers for its grant", g, wait_cnt[g]));
      end
      wait_cnt[g] = 0;
      record_request(g);
    end
  endtask

  task automatic wait_accept(int c);
    int n;
    n = 0;
    while (!done[c]) begin
      n++;
      if (n > 50) begin
        stop_run("timeout waiting for a request to be accepted");
      end
      edge_drive();
      sample_ports();
    end
  endtask

  task automatic issue(int c, l2_pkg::l2_req_t r);
    edge_drive();
    req_drv[c] = r;
    sample_ports();
    wait_accept(c);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((exp_q.size() != 0) || req_drv[0].valid || req_drv[1].valid || req_drv[2].valid) begin
      n++;
      if (n > 500) begin
        stop_run("timeout waiting for outstanding requests to drain");
      end
      edge_drive();
      sample_ports();
    end
  endtask

  // One request alone, all readies high
  task automatic run_latency_test();
    l2_pkg::l2_req_t r;
    int              n;
    int              start;
    r          = '0;
    r.valid    = 1'b1;
    r.req_type = l2_pkg::IReadLine;
    r.paddr    = 8'h5a;
    r.wbb_tag  = 4'h3;
    issue(0, r);
    start = acc_cyc;
    n = 0;
    while (!ans_seen) begin
      n++;
      if (n > 20) begin
        stop_run("timeout waiting for the answer of a single request");
      end
      edge_drive();
      sample_ports();
    end
    // Sample cyc follows edge cyc-1, acceptance was edge start
    check_eq("answer latency in cycles", 3, cyc - 1 - start);
  endtask

  task automatic run_flush_test();
    l2_pkg::l2_req_t r;
    logic [255:0]    b;
    r          = '0;
    r.valid    = 1'b1;
    r.req_type = l2_pkg::DWriteLine;
    b          = take_bits(8);
    r.paddr    = b[7:0];
    r.line     = take_bits(256);
    r.wbb_tag  = 4'h9;
    issue(1, r);
    // Flush during the cycle after acceptance
    edge_drive();
    flush_i = 1'b1;
    sample_ports();
    edge_drive();
    flush_i = 1'b0;
    // The dropped write never happened
    void'(exp_q.pop_back());
    ref_mem[{r.paddr.tag, r.paddr.idx}] = last_old;
    sample_ports();
    repeat (6) begin
      edge_drive();
      sample_ports();
    end
    r.req_type = l2_pkg::DReadLine;
    r.line     = '0;
    r.wbb_tag  = 4'ha;
    issue(1, r);
    r.req_type = l2_pkg::PTWLoad;
    r.wbb_tag  = 4'hb;
    issue(2, r);
    wait_idle();
  endtask

  initial begin
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    flush_i  = 1'b0;
    ans_rdy  = '1;
    done     = '0;
    lfsr_q   = 32'd64;
    cyc      = 0;
    acc_cyc  = 0;
    rand_en  = 1'b0;
    ans_seen = 1'b0;
    held     = 1'b0;
    held_c   = 0;
    held_ans = '0;
    last_old = '0;
    for (int c = 0; c < 3; c++) begin
      req_drv[c]  = '0;
      wait_cnt[c] = 0;
    end
    for (int i = 0; i < l2_pkg::MemLines; i++) begin
      ref_mem[i] = '0;
    end
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    run_latency_test();
    // Random traffic with answer back-pressure
    rand_en = 1'b1;
    repeat (3000) begin
      edge_drive();
      sample_ports();
    end
    rand_en = 1'b0;
    wait_idle();
    run_flush_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: l2_subsystem.f
design/l2_pkg.sv
design/l2_line_mem.sv
design/l2_arbiter.sv
design/l2_req_buffer.sv
design/l2_subsystem.sv
tb/l2_subsystem_assertions.sv
tb/tb_l2_subsystem.sv

// File: Bender.yml
package:
  name: l2_subsystem

sources:
  # Design, in compile order
  - design/l2_pkg.sv
  - design/l2_line_mem.sv
  - design/l2_arbiter.sv
  - design/l2_req_buffer.sv
  - design/l2_subsystem.sv

  # Testbench
  - target: test
    files:
      - tb/l2_subsystem_assertions.sv
      - tb/tb_l2_subsystem.sv
